// File: design/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Instructions renamed per cycle
`define RN_FETCH_WIDTH 4

// Integer architectural registers
`define RN_ARCH_REGS 32

// Integer physical register file entries
`define RN_PREG_SIZE 64

// Reorder buffer entries
`define RN_ROB_SIZE 32

`endif

// File: design/rename_types_pkg.sv
`include "rename_macros.svh"

package rename_types_pkg;

    localparam int AREG_W = $clog2(`RN_ARCH_REGS);
    localparam int PREG_W = $clog2(`RN_PREG_SIZE);
    localparam int LANE_W = $clog2(`RN_FETCH_WIDTH);
    localparam int CNT_W  = $clog2(`RN_FETCH_WIDTH + 1);

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [LANE_W-1:0] lane_idx_t;
    typedef logic [CNT_W-1:0]  lane_cnt_t;

    // Decoded fields that rename looks at
    typedef struct packed {
        logic  valid;
        logic  we;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
    } dec_op_t;

    // Physical registers handed on to dispatch
    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
    } ren_op_t;

endpackage

// File: design/backend_ctrl_pkg.sv
`include "rename_macros.svh"

package backend_ctrl_pkg;

    localparam int ROB_W = $clog2(`RN_ROB_SIZE);

    typedef logic [ROB_W-1:0] rob_idx_t;

    // dir flips every time the index wraps
    typedef struct packed {
        logic     dir;
        rob_idx_t idx;
    } rob_ptr_t;

    // One retiring instruction
    typedef struct packed {
        logic                    valid;
        logic                    we;
        rename_types_pkg::areg_t rd;
        rename_types_pkg::preg_t prd;
        rename_types_pkg::preg_t old_prd;
    } commit_entry_t;

endpackage

// File: design/rename_if.sv
`include "rename_macros.svh"

// Map table lookup and update, one entry per lane
interface rat_if;

    rename_types_pkg::areg_t     rs1     [`RN_FETCH_WIDTH];
    rename_types_pkg::areg_t     rs2     [`RN_FETCH_WIDTH];
    rename_types_pkg::areg_t     rd      [`RN_FETCH_WIDTH];
    logic [`RN_FETCH_WIDTH-1:0]  we;
    rename_types_pkg::preg_t     new_prd [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t     prs1    [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t     prs2    [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t     cur_prd [`RN_FETCH_WIDTH];

    modport core (
        output rs1, rs2, rd, we, new_prd,
        input  prs1, prs2, cur_prd
    );

    modport tbl (
        input  rs1, rs2, rd, we, new_prd,
        output prs1, prs2, cur_prd
    );

endinterface

// Allocation port of the free list
interface freelist_if;

    rename_types_pkg::lane_cnt_t alloc_cnt;
    logic                        accept;
    rename_types_pkg::preg_t     free_prd [`RN_FETCH_WIDTH];
    logic                        full;

    modport core (output alloc_cnt, accept, input free_prd, full);

    modport list (input alloc_cnt, accept, output free_prd, full);

endinterface

// File: design/rename_map_table.sv
`include "rename_macros.svh"

module rename_map_table (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            redirect,
    input  backend_ctrl_pkg::commit_entry_t commit [`RN_FETCH_WIDTH],
    rat_if.tbl                              rat
);

    rename_types_pkg::preg_t spec_map  [`RN_ARCH_REGS];
    rename_types_pkg::preg_t arch_map  [`RN_ARCH_REGS];
    rename_types_pkg::preg_t arch_next [`RN_ARCH_REGS];

    // Lookups return the speculative state before this edge
    for (genvar i = 0; i < `RN_FETCH_WIDTH; i++) begin : g_lookup
        assign rat.prs1[i]    = spec_map[rat.rs1[i]];
        assign rat.prs2[i]    = spec_map[rat.rs2[i]];
        assign rat.cur_prd[i] = spec_map[rat.rd[i]];
    end

    // Commit lanes in order, so a later lane to the same rd wins
    always_comb begin
        arch_next = arch_map;
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            if (commit[i].valid && commit[i].we) begin
                arch_next[commit[i].rd] = commit[i].prd;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                arch_map[r] <= rename_types_pkg::preg_t'(r);
            end
        end else begin
            arch_map <= arch_next;
        end
    end

    // Redirect restores from the architectural view including this cycle's commits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `RN_ARCH_REGS; r++) begin
                spec_map[r] <= rename_types_pkg::preg_t'(r);
            end
        end else if (redirect) begin
            spec_map <= arch_next;
        end else begin
            // At most one lane per rd has we set
            for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
                if (rat.we[i]) begin
                    spec_map[rat.rd[i]] <= rat.new_prd[i];
                end
            end
        end
    end

endmodule

// File: design/rename_free_list.sv
`include "rename_macros.svh"

module rename_free_list (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            redirect,
    input  backend_ctrl_pkg::commit_entry_t commit [`RN_FETCH_WIDTH],
    freelist_if.list                        fl
);

    localparam int FL_SIZE = `RN_PREG_SIZE - `RN_ARCH_REGS;
    localparam int FL_W    = $clog2(FL_SIZE);

    // Pointers carry one extra wrap bit
    typedef logic [FL_W:0]   ptr_t;
    typedef logic [FL_W-1:0] slot_t;

    rename_types_pkg::preg_t     slots    [FL_SIZE];
    ptr_t                        head;
    ptr_t                        cmt_head;
    ptr_t                        tail;
    ptr_t                        cmt_next;
    ptr_t                        free_cnt;
    logic [`RN_FETCH_WIDTH-1:0]  rel_en;
    slot_t                       rel_slot [`RN_FETCH_WIDTH];
    rename_types_pkg::lane_cnt_t rel_cnt;

    for (genvar k = 0; k < `RN_FETCH_WIDTH; k++) begin : g_offer
        assign fl.free_prd[k] = slots[slot_t'(head) + slot_t'(k)];
    end

    // Released registers pack densely at the tail in lane order
    always_comb begin
        rename_types_pkg::lane_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            rel_en[i]   = commit[i].valid & commit[i].we;
            rel_slot[i] = slot_t'(tail) + slot_t'(cnt);
            if (rel_en[i]) begin
                cnt = cnt + 1'b1;
            end
        end
        rel_cnt = cnt;
    end

    assign cmt_next = cmt_head + ptr_t'(rel_cnt);
    assign free_cnt = tail - head;
    assign fl.full  = free_cnt < ptr_t'(`RN_FETCH_WIDTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Everything above the architectural set starts free
            for (int s = 0; s < FL_SIZE; s++) begin
                slots[s] <= rename_types_pkg::preg_t'(`RN_ARCH_REGS + s);
            end
            head     <= '0;
            cmt_head <= '0;
            tail     <= ptr_t'(FL_SIZE);
        end else begin
            for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
                if (rel_en[i]) begin
                    slots[rel_slot[i]] <= commit[i].old_prd;
                end
            end
            tail     <= tail + ptr_t'(rel_cnt);
            cmt_head <= cmt_next;
            if (redirect) begin
                head <= cmt_next;
            end else if (fl.accept) begin
                head <= head + ptr_t'(fl.alloc_cnt);
            end
        end
    end

endmodule

// File: design/rename_core.sv
`include "rename_macros.svh"

module rename_core (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            accept,
    input  logic                            redirect,
    input  rename_types_pkg::dec_op_t       op      [`RN_FETCH_WIDTH],
    input  backend_ctrl_pkg::commit_entry_t commit  [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t         prs1    [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t         prs2    [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t         prd     [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t         old_prd [`RN_FETCH_WIDTH],
    output logic                            full
);

    rat_if      rat ();
    freelist_if fl ();

    logic [`RN_FETCH_WIDTH-1:0]  rd_en;
    logic [`RN_FETCH_WIDTH-1:0]  last_wr;
    rename_types_pkg::lane_idx_t alloc_idx [`RN_FETCH_WIDTH];
    rename_types_pkg::lane_cnt_t alloc_cnt;

    rename_map_table map_table_i (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .commit   (commit),
        .rat      (rat)
    );

    rename_free_list free_list_i (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .commit   (commit),
        .fl       (fl)
    );

    // Each writing lane takes the next free entry in lane order
    always_comb begin
        rename_types_pkg::lane_cnt_t cnt;
        cnt = '0;
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            alloc_idx[i] = rename_types_pkg::lane_idx_t'(cnt);
            if (rd_en[i]) begin
                cnt = cnt + 1'b1;
            end
        end
        alloc_cnt = cnt;
    end

    for (genvar i = 0; i < `RN_FETCH_WIDTH; i++) begin : g_lane
        assign rd_en[i]       = op[i].valid & op[i].we;
        assign prd[i]         = rd_en[i] ? fl.free_prd[alloc_idx[i]] : '0;
        assign rat.rs1[i]     = op[i].rs1;
        assign rat.rs2[i]     = op[i].rs2;
        assign rat.rd[i]      = op[i].rd;
        assign rat.new_prd[i] = prd[i];
        assign rat.we[i]      = accept & last_wr[i];
    end

    // Nearest earlier writer overrides the table, since the loop runs upward
    always_comb begin
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            prs1[i]    = rat.prs1[i];
            prs2[i]    = rat.prs2[i];
            old_prd[i] = rat.cur_prd[i];
            for (int j = 0; j < i; j++) begin
                if (rd_en[j] && op[j].rd == op[i].rs1) begin
                    prs1[i] = prd[j];
                end
                if (rd_en[j] && op[j].rd == op[i].rs2) begin
                    prs2[i] = prd[j];
                end
                if (rd_en[j] && rd_en[i] && op[j].rd == op[i].rd) begin
                    old_prd[i] = prd[j];
                end
            end
        end
    end

    // WAW kill: a later writer of the same rd owns the table entry
    always_comb begin
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            last_wr[i] = rd_en[i];
            for (int j = i + 1; j < `RN_FETCH_WIDTH; j++) begin
                if (rd_en[j] && op[j].rd == op[i].rd) begin
                    last_wr[i] = 1'b0;
                end
            end
        end
    end

    assign fl.alloc_cnt = alloc_cnt;
    assign fl.accept    = accept;
    assign full         = fl.full;

endmodule

// File: design/rename_stage.sv
`include "rename_macros.svh"

module rename_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [`RN_FETCH_WIDTH-1:0]        in_valid,
    input  rename_types_pkg::areg_t           in_rs1         [`RN_FETCH_WIDTH],
    input  rename_types_pkg::areg_t           in_rs2         [`RN_FETCH_WIDTH],
    input  rename_types_pkg::areg_t           in_rd          [`RN_FETCH_WIDTH],
    input  logic [`RN_FETCH_WIDTH-1:0]        in_we,
    output logic                              full,
    input  backend_ctrl_pkg::rob_ptr_t        rob_tail,
    output rename_types_pkg::lane_cnt_t       valid_num,
    input  logic                              dis_stall,
    output logic [`RN_FETCH_WIDTH-1:0]        out_valid,
    output rename_types_pkg::preg_t           out_prs1       [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t           out_prs2       [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t           out_prd        [`RN_FETCH_WIDTH],
    output rename_types_pkg::preg_t           out_old_prd    [`RN_FETCH_WIDTH],
    output logic [`RN_FETCH_WIDTH-1:0]        out_we,
    output backend_ctrl_pkg::rob_idx_t        out_rob_idx    [`RN_FETCH_WIDTH],
    output logic [`RN_FETCH_WIDTH-1:0]        out_rob_dir,
    input  logic [`RN_FETCH_WIDTH-1:0]        commit_valid,
    input  logic [`RN_FETCH_WIDTH-1:0]        commit_we,
    input  rename_types_pkg::areg_t           commit_rd      [`RN_FETCH_WIDTH],
    input  rename_types_pkg::preg_t           commit_prd     [`RN_FETCH_WIDTH],
    input  rename_types_pkg::preg_t           commit_old_prd [`RN_FETCH_WIDTH],
    input  logic                              redirect
);

    localparam int ROB_W = backend_ctrl_pkg::ROB_W;

    rename_types_pkg::dec_op_t       op       [`RN_FETCH_WIDTH];
    backend_ctrl_pkg::commit_entry_t commit   [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t         prs1     [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t         prs2     [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t         prd      [`RN_FETCH_WIDTH];
    rename_types_pkg::preg_t         old_prd  [`RN_FETCH_WIDTH];
    rename_types_pkg::ren_op_t       out_q    [`RN_FETCH_WIDTH];
    backend_ctrl_pkg::rob_idx_t      rob_idx  [`RN_FETCH_WIDTH];
    logic [`RN_FETCH_WIDTH-1:0]      rob_dir;
    logic                            accept;

    assign accept = ~dis_stall & ~redirect & ~full;

    for (genvar i = 0; i < `RN_FETCH_WIDTH; i++) begin : g_lane
        logic [ROB_W:0] rob_sum;

        assign op[i]     = '{valid: in_valid[i], we: in_we[i], rs1: in_rs1[i],
                             rs2: in_rs2[i], rd: in_rd[i]};
        assign commit[i] = '{valid: commit_valid[i], we: commit_we[i], rd: commit_rd[i],
                             prd: commit_prd[i], old_prd: commit_old_prd[i]};

        // Carry out of the index flips the direction bit
        assign rob_sum    = {1'b0, rob_tail.idx} + (ROB_W + 1)'(i);
        assign rob_idx[i] = rob_sum[ROB_W-1:0];
        assign rob_dir[i] = rob_tail.dir ^ rob_sum[ROB_W];

        assign out_prs1[i]    = out_q[i].prs1;
        assign out_prs2[i]    = out_q[i].prs2;
        assign out_prd[i]     = out_q[i].prd;
        assign out_old_prd[i] = out_q[i].old_prd;
    end

    always_comb begin
        valid_num = '0;
        for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
            valid_num = valid_num + rename_types_pkg::lane_cnt_t'(in_valid[i]);
        end
    end

    rename_core core_i (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .redirect (redirect),
        .op       (op),
        .commit   (commit),
        .prs1     (prs1),
        .prs2     (prs2),
        .prd      (prd),
        .old_prd  (old_prd),
        .full     (full)
    );

    // Payload only moves when dispatch can take it
    always_ff @(posedge clk) begin
        if (!dis_stall) begin
            for (int i = 0; i < `RN_FETCH_WIDTH; i++) begin
                out_q[i]       <= '{prs1: prs1[i], prs2: prs2[i], prd: prd[i],
                                    old_prd: old_prd[i]};
                out_rob_idx[i] <= rob_idx[i];
                out_rob_dir[i] <= rob_dir[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= '0;
            out_we    <= '0;
        end else if (redirect) begin
            out_valid <= '0;
            out_we    <= '0;
        end else if (!dis_stall) begin
            if (full) begin
                // Bubble while the decoder holds its group
                out_valid <= '0;
                out_we    <= '0;
            end else begin
                out_valid <= in_valid;
                out_we    <= in_valid & in_we;
            end
        end
    end

endmodule

// File: test/rename_stage_props.sv
`include "rename_macros.svh"

module rename_stage_props (
    input logic                       clk,
    input logic                       rst,
    input logic                       redirect,
    input logic                       dis_stall,
    input logic [`RN_FETCH_WIDTH-1:0] out_valid,
    input logic [`RN_FETCH_WIDTH-1:0] out_we,
    input logic [`RN_FETCH_WIDTH-1:0] out_rob_dir,
    input rename_types_pkg::preg_t    out_prd [`RN_FETCH_WIDTH]
);

    // A lane that writes must also be a valid lane
    we_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (out_we & ~out_valid) == '0)
        else $error("out_we is set on a lane whose out_valid is low");

    flush_clears_valid: assert property (@(posedge clk) disable iff (rst)
        redirect |=> out_valid == '0)
        else $error("out_valid is still set in the cycle after a redirect");

    stall_holds_ctrl: assert property (@(posedge clk) disable iff (rst)
        (dis_stall && !redirect) |=> $stable(out_valid) && $stable(out_we)
            && $stable(out_rob_dir))
        else $error("out control bits changed while dispatch was stalled");

    for (genvar i = 0; i < `RN_FETCH_WIDTH; i++) begin : g_lane
        stall_holds_prd: assert property (@(posedge clk) disable iff (rst)
            dis_stall |=> $stable(out_prd[i]))
            else $error("out_prd changed while dispatch was stalled");
    end

endmodule

// File: test/rename_stage_tb.sv
`include "rename_macros.svh"

module rename_stage_tb;

    localparam int W              = `RN_FETCH_WIDTH;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                        clk;
    logic                        rst;
    logic [W-1:0]                in_valid;
    rename_types_pkg::areg_t     in_rs1 [W];
    rename_types_pkg::areg_t     in_rs2 [W];
    rename_types_pkg::areg_t     in_rd  [W];
    logic [W-1:0]                in_we;
    logic                        full;
    backend_ctrl_pkg::rob_ptr_t  rob_tail;
    rename_types_pkg::lane_cnt_t valid_num;
    logic                        dis_stall;
    logic [W-1:0]                out_valid;
    rename_types_pkg::preg_t     out_prs1    [W];
    rename_types_pkg::preg_t     out_prs2    [W];
    rename_types_pkg::preg_t     out_prd     [W];
    rename_types_pkg::preg_t     out_old_prd [W];
    logic [W-1:0]                out_we;
    backend_ctrl_pkg::rob_idx_t  out_rob_idx [W];
    logic [W-1:0]                out_rob_dir;
    logic [W-1:0]                commit_valid;
    logic [W-1:0]                commit_we;
    rename_types_pkg::areg_t     commit_rd      [W];
    rename_types_pkg::preg_t     commit_prd     [W];
    rename_types_pkg::preg_t     commit_old_prd [W];
    logic                        redirect;

    // Reference model
    int spec_map [`RN_ARCH_REGS];
    int arch_map [`RN_ARCH_REGS];
    int free_q   [$];
    int alloc_q  [$];
    // Renamed writers waiting for commit, oldest first
    int ret_rd   [$];
    int ret_prd  [$];
    int ret_old  [$];

    // What the dispatch register should hold
    logic [W-1:0] exp_valid;
    logic [W-1:0] exp_we;
    int exp_prs1 [W];
    int exp_prs2 [W];
    int exp_prd  [W];
    int exp_old  [W];
    int exp_idx  [W];
    int exp_dir  [W];

    int seed   = 71;
    int cycles = 0;

    rename_stage rename_stage_i (.*);

    bind rename_stage rename_stage_props props_i (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .dis_stall   (dis_stall),
        .out_valid   (out_valid),
        .out_we      (out_we),
        .out_rob_dir (out_rob_dir),
        .out_prd     (out_prd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Tests take under a hundred cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_with($sformatf("Timeout: the run did not finish in %0d cycles", cycles));
        end
    end

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else fail_with($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic init_model();
        for (int r = 0; r < `RN_ARCH_REGS; r++) begin
            spec_map[r] = r;
            arch_map[r] = r;
        end
        for (int p = `RN_ARCH_REGS; p < `RN_PREG_SIZE; p++) begin
            free_q.push_back(p);
        end
        exp_valid = '0;
        exp_we    = '0;
    endtask

    task automatic set_lane(input int i, input logic we, input int rs1, input int rs2,
                            input int rd);
        in_valid[i] = 1'b1;
        in_we[i]    = we;
        in_rs1[i]   = rename_types_pkg::areg_t'(rs1);
        in_rs2[i]   = rename_types_pkg::areg_t'(rs2);
        in_rd[i]    = rename_types_pkg::areg_t'(rd);
    endtask

    task automatic random_group();
        for (int i = 0; i < W; i++) begin
            in_valid[i] = ($random(seed) & 3) != 0;
            in_we[i]    = ($random(seed) & 3) != 0;
            in_rs1[i]   = rename_types_pkg::areg_t'($random(seed));
            in_rs2[i]   = rename_types_pkg::areg_t'($random(seed));
            in_rd[i]    = rename_types_pkg::areg_t'($random(seed));
        end
    endtask

    function automatic int commit_count(input int n);
        return (n > ret_rd.size()) ? ret_rd.size() : n;
    endfunction

    // Lanes renamed one after another, so earlier writers shadow the map
    task automatic rename_group();
        int p;
        for (int i = 0; i < W; i++) begin
            exp_idx[i] = (int'(rob_tail.idx) + i) % `RN_ROB_SIZE;
            exp_dir[i] = rob_tail.dir ^ ((int'(rob_tail.idx) + i) >= `RN_ROB_SIZE);
            if (in_valid[i]) begin
                exp_prs1[i] = spec_map[in_rs1[i]];
                exp_prs2[i] = spec_map[in_rs2[i]];
                exp_prd[i]  = 0;
                if (in_we[i]) begin
                    p = free_q.pop_front();
                    exp_old[i] = spec_map[in_rd[i]];
                    exp_prd[i] = p;
                    spec_map[in_rd[i]] = p;
                    alloc_q.push_back(p);
                    ret_rd.push_back(in_rd[i]);
                    ret_prd.push_back(p);
                    ret_old.push_back(exp_old[i]);
                end
            end
        end
        exp_valid = in_valid;
        exp_we    = in_valid & in_we;
    endtask

    task automatic check_outputs();
        check_field("out_valid", 32'(out_valid), 32'(exp_valid));
        check_field("out_we", 32'(out_we), 32'(exp_we));
        check_field("valid_num", 32'(valid_num), $countones(in_valid));
        for (int i = 0; i < W; i++) begin
            if (exp_valid[i]) begin
                check_field($sformatf("out_prs1[%0d]", i), 32'(out_prs1[i]), exp_prs1[i]);
                check_field($sformatf("out_prs2[%0d]", i), 32'(out_prs2[i]), exp_prs2[i]);
                check_field($sformatf("out_prd[%0d]", i), 32'(out_prd[i]), exp_prd[i]);
                check_field($sformatf("out_rob_idx[%0d]", i), 32'(out_rob_idx[i]), exp_idx[i]);
                check_field($sformatf("out_rob_dir[%0d]", i), 32'(out_rob_dir[i]), exp_dir[i]);
                if (exp_we[i]) begin
                    check_field($sformatf("out_old_prd[%0d]", i), 32'(out_old_prd[i]),
                                exp_old[i]);
                end
            end
        end
    endtask

    // Called at the drive point, returns at the next one
    task automatic run_cycle(input int n_commit, input logic stall, input logic flush);
        int   total;
        logic accepted;
        accepted = !stall && !flush && free_q.size() >= W;
        check_field("full", 32'(full), 32'(free_q.size() < W));
        commit_valid = '0;
        commit_we    = '0;
        for (int i = 0; i < n_commit; i++) begin
            commit_valid[i]   = 1'b1;
            commit_we[i]      = 1'b1;
            commit_rd[i]      = rename_types_pkg::areg_t'(ret_rd.pop_front());
            commit_prd[i]     = rename_types_pkg::preg_t'(ret_prd.pop_front());
            commit_old_prd[i] = rename_types_pkg::preg_t'(ret_old.pop_front());
        end
        dis_stall = stall;
        redirect  = flush;
        if (accepted) begin
            rename_group();
        end else if (flush || !stall) begin
            exp_valid = '0;
            exp_we    = '0;
        end
        // Freed registers only become visible next cycle
        for (int i = 0; i < n_commit; i++) begin
            arch_map[commit_rd[i]] = commit_prd[i];
            alloc_q.delete(0);
            free_q.push_back(commit_old_prd[i]);
        end
        if (flush) begin
            spec_map = arch_map;
            while (alloc_q.size() > 0) begin
                free_q.push_front(alloc_q.pop_back());
            end
            ret_rd.delete();
            ret_prd.delete();
            ret_old.delete();
        end
        @(posedge clk);
        #5;
        check_outputs();
        if (accepted) begin
            total = int'(rob_tail.idx) + $countones(in_valid);
            rob_tail.dir = rob_tail.dir ^ (total >= `RN_ROB_SIZE);
            rob_tail.idx = backend_ctrl_pkg::rob_idx_t'(total % `RN_ROB_SIZE);
        end
        commit_valid = '0;
        commit_we    = '0;
        dis_stall    = 1'b0;
        redirect     = 1'b0;
    endtask

    task automatic test_first_group();
        check_field("out_valid", 32'(out_valid), 32'h0);
        for (int i = 0; i < W; i++) begin
            set_lane(i, 1'b1, 8 + i, 16 + i, 1 + i);
        end
        run_cycle(0, 1'b0, 1'b0);
        // Identity map, and p32 upward off the free list
        for (int i = 0; i < W; i++) begin
            check_field($sformatf("out_prs1[%0d]", i), 32'(out_prs1[i]), 8 + i);
            check_field($sformatf("out_prd[%0d]", i), 32'(out_prd[i]), `RN_ARCH_REGS + i);
        end
    endtask

    task automatic test_bypass();
        set_lane(0, 1'b1, 1, 2, 7);
        set_lane(1, 1'b1, 7, 3, 7);
        set_lane(2, 1'b1, 7, 7, 9);
        set_lane(3, 1'b1, 9, 4, 7);
        run_cycle(0, 1'b0, 1'b0);
        in_valid = '0;
        in_we    = '0;
        set_lane(0, 1'b0, 7, 9, 0);
        run_cycle(0, 1'b0, 1'b0);
    endtask

    task automatic test_random();
        int n;
        for (int k = 0; k < 24; k++) begin
            random_group();
            n = commit_count(($random(seed) & 7) % (W + 1));
            run_cycle(n, 1'b0, 1'b0);
        end
    endtask

    task automatic test_stall();
        random_group();
        run_cycle(commit_count(W), 1'b0, 1'b0);
        random_group();
        repeat (3) run_cycle(0, 1'b1, 1'b0);
        run_cycle(0, 1'b0, 1'b0);
    endtask

    task automatic test_exhaustion();
        for (int i = 0; i < W; i++) begin
            set_lane(i, 1'b1, i, i + 1, 10 + i);
        end
        while (free_q.size() >= W) begin
            run_cycle(0, 1'b0, 1'b0);
        end
        // Full now, so the held group turns into bubbles until commits land
        run_cycle(0, 1'b0, 1'b0);
        run_cycle(commit_count(W), 1'b0, 1'b0);
        run_cycle(0, 1'b0, 1'b0);
    endtask

    task automatic test_redirect();
        random_group();
        run_cycle(commit_count(W), 1'b0, 1'b0);
        run_cycle(commit_count(W), 1'b0, 1'b0);
        random_group();
        run_cycle(commit_count(2), 1'b0, 1'b1);
        random_group();
        run_cycle(0, 1'b0, 1'b0);
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = '0;
        in_we        = '0;
        rob_tail     = '0;
        dis_stall    = 1'b0;
        commit_valid = '0;
        commit_we    = '0;
        redirect     = 1'b0;
        for (int i = 0; i < W; i++) begin
            in_rs1[i]         = '0;
            in_rs2[i]         = '0;
            in_rd[i]          = '0;
            commit_rd[i]      = '0;
            commit_prd[i]     = '0;
            commit_old_prd[i] = '0;
        end
        init_model();
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        test_first_group();
        test_bypass();
        test_random();
        test_stall();
        test_exhaustion();
        test_redirect();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: rename_stage.f
+incdir+design
design/rename_types_pkg.sv
design/backend_ctrl_pkg.sv
design/rename_if.sv
design/rename_map_table.sv
design/rename_free_list.sv
design/rename_core.sv
design/rename_stage.sv
test/rename_stage_props.sv
test/rename_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the rename stage testbench, exit status is the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f rename_stage.f \
        --top-module rename_stage_tb \
    && ./obj_dir/Vrename_stage_tb \
    || exit 1
